// ==== Bender.yml ====
package:
  name: arcade_frontend

sources:
  - files:
      - frontend_pkg.sv
      - ioctl_sink.sv
      - pause_ctrl.sv
      - core_bridge.sv
      - frontend_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_frontend.sv

// ==== core_bridge.sv ====
// Core-facing output register stage
`timescale 1ns/100ps

module core_bridge (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	// Player inputs
	input  frontend_pkg::joy_t       joy,
	// Switch bank entries from the download decoder
	input  frontend_pkg::dip1_u      dip_bank1,
	input  logic [7:0]               dip_bank2,
	input  logic                     rom_wr,
	// Dim level from the pause block
	input  logic                     dim,
	// Core pixel, 3-3-2
	input  frontend_pkg::rgb332_t    rgb_in,
	// Active-low controls to the core
	output frontend_pkg::core_ctrl_t controls,
	output logic [7:0]               dip1,
	output logic [7:0]               dip2,
	output logic                     rom_wr_core,
	output frontend_pkg::rgb332_t    rgb_out
);

	// ========================================
	// Next-state values
	// ========================================

	frontend_pkg::core_ctrl_t ctrl_next;
	frontend_pkg::dip1_u      dip1_next;
	frontend_pkg::rgb332_t    rgb_next;

	always_comb begin
		// Core wants pressed = 0
		ctrl_next.coin    = ~joy.coin;
		ctrl_next.start2p = ~joy.start2p;
		ctrl_next.start1p = ~joy.start1p;
		// Fast fire drives the second shoot line
		ctrl_next.shoot2  = ~joy.fast_fire;
		ctrl_next.shoot   = ~joy.fire;
		ctrl_next.up      = ~joy.up;
		ctrl_next.down    = ~joy.down;
		ctrl_next.left    = ~joy.left;
		ctrl_next.right   = ~joy.right;

		// Table mode is not supported, force upright
		dip1_next           = dip_bank1;
		dip1_next.f.cabinet = 1'b0;

		// Half brightness per channel when dimmed
		if (dim) begin
			rgb_next.r = rgb_in.r >> 1;
			rgb_next.g = rgb_in.g >> 1;
			rgb_next.b = rgb_in.b >> 1;
		end else begin
			rgb_next = rgb_in;
		end
	end

	// ========================================
	// Output registers
	// ========================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			// All controls released
			controls    <= '1;
			dip1        <= 8'd0;
			dip2        <= 8'd0;
			rom_wr_core <= 1'b0;
			rgb_out     <= '0;
		end else begin
			controls    <= ctrl_next;
			dip1        <= dip1_next.raw;
			dip2        <= dip_bank2;
			rom_wr_core <= rom_wr;
			rgb_out     <= rgb_next;
		end
	end

endmodule

// ==== files.f ====
frontend_pkg.sv
ioctl_sink.sv
pause_ctrl.sv
core_bridge.sv
frontend_top.sv
tb_checker.sv
tb_frontend.sv

// ==== frontend_pkg.sv ====
// Arcade front end shared types
package frontend_pkg;

	// ========================================
	// Host download channel
	// ========================================

	// One byte of the download stream, as seen on a single clock
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_beat_t;

	// Index carrying the DIP switch bytes
	localparam logic [7:0] DIP_INDEX_DEF = 8'd254;

	// ========================================
	// Player inputs
	// ========================================

	// Joystick word, bit 0 at the bottom of the list
	typedef struct packed {
		logic [5:0] spare;
		logic       pause;
		logic       coin;
		logic       start2p;
		logic       start1p;
		logic       fast_fire;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Core control bus, all active low, coin at the top
	typedef struct packed {
		logic coin;
		logic start2p;
		logic start1p;
		logic shoot2;
		logic shoot;
		logic up;
		logic down;
		logic left;
		logic right;
	} core_ctrl_t;

	// ========================================
	// DIP switch byte 1
	// ========================================

	// Field layout of switch bank 1, cabinet in the MSB
	typedef struct packed {
		logic       cabinet;
		logic [1:0] difficulty;
		logic [1:0] bonus;
		logic [2:0] fighters;
	} dip1_fields_t;

	// Written as a byte by the download decoder, read by field in the bridge
	typedef union packed {
		logic [7:0]   raw;
		dip1_fields_t f;
	} dip1_u;

	// ========================================
	// Pause and video
	// ========================================

	// Menu options for the pause system
	typedef struct packed {
		logic pause_on_osd;
		logic dim_en;
	} pause_opts_t;

	// Cycles of pause before dimming, about 10 s at 20 MHz
	localparam int unsigned DIM_CYCLES_DEF = 200_000_000;

	// 3-3-2 pixel from the core
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb332_t;

endpackage

// ==== frontend_top.sv ====
// Arcade host front end top level
`timescale 1ns/100ps

module frontend_top #(
	// Download index of the DIP bytes
	parameter logic [7:0]  DIP_INDEX  = frontend_pkg::DIP_INDEX_DEF,
	// Paused cycles before dimming
	parameter int unsigned DIM_CYCLES = frontend_pkg::DIM_CYCLES_DEF
) (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	// Host side
	input  frontend_pkg::ioctl_beat_t beat,
	input  frontend_pkg::joy_t        joy,
	input  logic                      osd_status,
	input  logic                      hs_pause_req,
	input  frontend_pkg::pause_opts_t pause_opts,
	// Pixel from the core
	input  frontend_pkg::rgb332_t     rgb_in,
	// Core side
	output frontend_pkg::core_ctrl_t  controls,
	output logic [7:0]                dip1,
	output logic [7:0]                dip2,
	output logic                      rom_wr_core,
	output logic                      pause_cpu,
	output frontend_pkg::rgb332_t     rgb_out
);

	// ========================================
	// Internal links
	// ========================================

	frontend_pkg::dip1_u dip_bank1;
	logic [7:0]          dip_bank2;
	logic                rom_wr;
	logic                dim;

	// Download stream into switch bank and ROM strobe
	ioctl_sink #(
		.DIP_INDEX(DIP_INDEX)
	) ioctl_sink_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.beat     (beat),
		.dip_bank1(dip_bank1),
		.dip_bank2(dip_bank2),
		.rom_wr   (rom_wr)
	);

	// Pause sources and dimming, button comes from the joystick word
	pause_ctrl #(
		.DIM_CYCLES(DIM_CYCLES)
	) pause_ctrl_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.pause_btn   (joy.pause),
		.osd_status  (osd_status),
		.hs_pause_req(hs_pause_req),
		.opts        (pause_opts),
		.pause_cpu   (pause_cpu),
		.dim         (dim)
	);

	// Final register stage towards the game
	core_bridge core_bridge_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.joy        (joy),
		.dip_bank1  (dip_bank1),
		.dip_bank2  (dip_bank2),
		.rom_wr     (rom_wr),
		.dim        (dim),
		.rgb_in     (rgb_in),
		.controls   (controls),
		.dip1       (dip1),
		.dip2       (dip2),
		.rom_wr_core(rom_wr_core),
		.rgb_out    (rgb_out)
	);

endmodule

// ==== ioctl_sink.sv ====
// Download stream decoder
`timescale 1ns/100ps

module ioctl_sink #(
	// Download index that carries the DIP switch bytes
	parameter logic [7:0] DIP_INDEX = frontend_pkg::DIP_INDEX_DEF
) (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	// One download beat per clock
	input  frontend_pkg::ioctl_beat_t beat,
	// Switch bank entries used by the core
	output frontend_pkg::dip1_u       dip_bank1,
	output logic [7:0]                dip_bank2,
	// Single-cycle ROM write strobe
	output logic                      rom_wr
);

	// ========================================
	// Beat decode
	// ========================================

	// Switch bytes only live in the first eight addresses
	logic dip_hit;
	// ROM image is always sent with index zero
	logic rom_hit;

	assign dip_hit = beat.wr && (beat.index == DIP_INDEX) && (beat.addr[24:3] == '0);
	assign rom_hit = beat.wr && (beat.index == 8'd0);

	// ========================================
	// Switch bank
	// ========================================

	// Eight bytes as the menu sends them
	// Only entries 1 and 2 drive the core, the rest are just held
	logic [7:0] bank [8];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			// Bank reads as all switches off until the menu sends it
			for (int i = 0; i < 8; i++) begin
				bank[i] <= 8'd0;
			end
		end else if (dip_hit) begin
			bank[beat.addr[2:0]] <= beat.dout;
		end
	end

	// Raw byte view, the bridge picks the fields apart
	assign dip_bank1.raw = bank[1];
	assign dip_bank2     = bank[2];

	// ========================================
	// ROM write strobe
	// ========================================

	// One pulse per ROM byte, lands the cycle after the beat
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_wr <= 1'b0;
		end else begin
			rom_wr <= rom_hit;
		end
	end

endmodule

// ==== pause_ctrl.sv ====
// Pause and dim control
`timescale 1ns/100ps

module pause_ctrl #(
	// Paused cycles before the picture dims, at least 1
	parameter int unsigned DIM_CYCLES = frontend_pkg::DIM_CYCLES_DEF
) (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	// Joystick pause button, level
	input  logic                      pause_btn,
	// OSD menu open
	input  logic                      osd_status,
	// Pause request from the high-score engine
	input  logic                      hs_pause_req,
	input  frontend_pkg::pause_opts_t opts,
	// Halt to the core
	output logic                      pause_cpu,
	// Picture dimming level
	output logic                      dim
);

	// Counter wide enough to hold DIM_CYCLES itself
	localparam int unsigned CNT_W = $clog2(DIM_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(DIM_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIM_CYCLES - 1);

	// ========================================
	// User toggle
	// ========================================

	logic btn_q;
	logic btn_rise;
	logic toggle;
	// Toggle value including this cycle's press
	logic toggle_next;

	assign btn_rise    = pause_btn && !btn_q;
	assign toggle_next = toggle ^ btn_rise;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			btn_q  <= 1'b0;
			toggle <= 1'b0;
		end else begin
			btn_q  <= pause_btn;
			toggle <= toggle_next;
		end
	end

	// ========================================
	// Pause merge
	// ========================================

	// Any source halts the core, menu only when enabled
	// Press is seen on the same edge as the other sources
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pause_cpu <= 1'b0;
		end else begin
			pause_cpu <= toggle_next || hs_pause_req ||
				(osd_status && opts.pause_on_osd);
		end
	end

	// ========================================
	// Dim timer
	// ========================================

	logic             dim_run;
	logic [CNT_W-1:0] dim_cnt;

	// Counts only while paused and the option is on
	assign dim_run = pause_cpu && opts.dim_en;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dim_cnt <= '0;
			dim     <= 1'b0;
		end else if (dim_run) begin
			// Saturate at the limit, dim holds from there
			if (dim_cnt != CNT_MAX) begin
				dim_cnt <= dim_cnt + 1'b1;
			end
			// Set on the edge where the count reaches the limit
			if (dim_cnt >= CNT_LAST) begin
				dim <= 1'b1;
			end
		end else begin
			// Any break restarts the wait
			dim_cnt <= '0;
			dim     <= 1'b0;
		end
	end

endmodule

// ==== tb_checker.sv ====
// Front end output checker
`timescale 1ns/100ps

module tb_checker (
	input  logic                     clk_sys,
	// Per-cycle compare active
	input  logic                     check_en,
	// DUT outputs
	input  frontend_pkg::core_ctrl_t controls,
	input  logic [7:0]               dip1,
	input  logic [7:0]               dip2,
	input  logic                     rom_wr_core,
	input  logic                     pause_cpu,
	input  frontend_pkg::rgb332_t    rgb_out,
	// Reference model values
	input  frontend_pkg::core_ctrl_t exp_controls,
	input  logic [7:0]               exp_dip1,
	input  logic [7:0]               exp_dip2,
	input  logic                     exp_rom_wr,
	input  logic                     exp_pause,
	input  frontend_pkg::rgb332_t    exp_rgb,
	// Errors over the whole run
	output int                       total_errs
);

	// ========================================
	// Counters
	// ========================================

	int test_checks;
	int test_errs;
	int tests_run;
	int tests_bad;

	initial begin
		total_errs  = 0;
		test_checks = 0;
		test_errs   = 0;
		tests_run   = 0;
		tests_bad   = 0;
	end

	// One value against its expected value
	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		test_checks++;
		if (act !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
			test_errs++;
			total_errs++;
		end
	endtask

	// Failure that is not a value mismatch
	task automatic fail_note(input string what);
		$display("t=%0t check failed: %s", $time, what);
		test_errs++;
		total_errs++;
	endtask

	// Outputs as they must read in and right after reset
	task automatic expect_idle();
		compare("controls", 16'h01ff, controls);
		compare("dip1", 16'h0000, dip1);
		compare("dip2", 16'h0000, dip2);
		compare("rom_wr_core", 16'h0000, rom_wr_core);
		compare("pause_cpu", 16'h0000, pause_cpu);
		compare("rgb_out", 16'h0000, rgb_out);
	endtask

	// ========================================
	// Cycle compare
	// ========================================

	// Falling edge, well clear of input changes and register updates
	always @(negedge clk_sys) begin
		if (check_en) begin
			compare("controls", exp_controls, controls);
			compare("dip1", exp_dip1, dip1);
			compare("dip2", exp_dip2, dip2);
			compare("rom_wr_core", exp_rom_wr, rom_wr_core);
			compare("pause_cpu", exp_pause, pause_cpu);
			compare("rgb_out", exp_rgb, rgb_out);
		end
	end

	// ========================================
	// Reports
	// ========================================

	// Closes the running test
	task automatic report_test(input string name);
		$display("test %-18s %0d checks, %0d errors, %s", name, test_checks, test_errs,
			(test_errs == 0) ? "ok" : "bad");
		tests_run++;
		if (test_errs != 0) begin
			tests_bad++;
		end
		test_checks = 0;
		test_errs   = 0;
	endtask

	task automatic report_totals();
		$display("summary: %0d tests, %0d with errors, %0d errors in total",
			tests_run, tests_bad, total_errs);
	endtask

endmodule

// ==== tb_frontend.sv ====
// Front end testbench
`timescale 1ns/100ps

module tb_frontend;

	localparam logic [7:0] DIP_INDEX  = 8'd254;
	localparam int         DIM_CYCLES = 16;
	// Test lengths in cycles, each test adds a short flush
	localparam int N_DIP   = 300;
	localparam int N_ROM   = 200;
	localparam int N_CTRL  = 200;
	localparam int N_PAUSE = 400;
	localparam int N_DIM   = 140;
	localparam int RUN_CYCLES  = 12 + N_DIP + N_ROM + N_CTRL + N_PAUSE + N_DIM + 5 * 4;
	localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * 10;

	logic                      clk_sys;
	logic                      rst_n;
	logic                      check_en;
	frontend_pkg::ioctl_beat_t beat;
	frontend_pkg::joy_t        joy;
	logic                      osd_status;
	logic                      hs_pause_req;
	frontend_pkg::pause_opts_t pause_opts;
	frontend_pkg::rgb332_t     rgb_in;
	frontend_pkg::core_ctrl_t  controls;
	logic [7:0]                dip1;
	logic [7:0]                dip2;
	logic                      rom_wr_core;
	logic                      pause_cpu;
	frontend_pkg::rgb332_t     rgb_out;
	logic [31:0]               seed;
	int                        total_errs;
	logic                      dim_seen;

	// Reference model state
	logic [7:0]               bank_m [8];
	logic                     rom_m;
	logic                     btn_m;
	logic                     toggle_m;
	logic                     toggle_now;
	logic                     pause_m;
	int                       run_m;
	logic                     dim_m;
	frontend_pkg::core_ctrl_t exp_controls;
	logic [7:0]               exp_dip1;
	logic [7:0]               exp_dip2;
	logic                     exp_rom_wr;
	frontend_pkg::rgb332_t    exp_rgb;

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	frontend_top #(
		.DIP_INDEX (DIP_INDEX),
		.DIM_CYCLES(DIM_CYCLES)
	) frontend_top_inst (
		.clk_sys(clk_sys), .rst_n(rst_n), .beat(beat), .joy(joy),
		.osd_status(osd_status), .hs_pause_req(hs_pause_req), .pause_opts(pause_opts),
		.rgb_in(rgb_in), .controls(controls), .dip1(dip1), .dip2(dip2),
		.rom_wr_core(rom_wr_core), .pause_cpu(pause_cpu), .rgb_out(rgb_out)
	);

	tb_checker checker_inst (
		.clk_sys(clk_sys), .check_en(check_en), .controls(controls), .dip1(dip1),
		.dip2(dip2), .rom_wr_core(rom_wr_core), .pause_cpu(pause_cpu), .rgb_out(rgb_out),
		.exp_controls(exp_controls), .exp_dip1(exp_dip1), .exp_dip2(exp_dip2),
		.exp_rom_wr(exp_rom_wr), .exp_pause(pause_m), .exp_rgb(exp_rgb),
		.total_errs(total_errs)
	);

	// ========================================
	// Reference model
	// ========================================

	// Toggle flips on a rising edge of the joystick pause bit
	assign toggle_now = toggle_m ^ (joy.pause & ~btn_m);

	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				bank_m[i] <= 8'd0;
			end
			rom_m        <= 1'b0;
			btn_m        <= 1'b0;
			toggle_m     <= 1'b0;
			pause_m      <= 1'b0;
			run_m        <= 0;
			dim_m        <= 1'b0;
			exp_controls <= '1;
			exp_dip1     <= 8'd0;
			exp_dip2     <= 8'd0;
			exp_rom_wr   <= 1'b0;
			exp_rgb      <= '0;
		end else begin
			// Switch bytes only at addresses 0 to 7
			if (beat.wr && beat.index == DIP_INDEX && beat.addr < 25'd8) begin
				bank_m[beat.addr[2:0]] <= beat.dout;
			end
			rom_m    <= beat.wr && beat.index == 8'd0;
			btn_m    <= joy.pause;
			toggle_m <= toggle_now;
			pause_m  <= toggle_now | hs_pause_req | (osd_status & pause_opts.pause_on_osd);
			// Length of the unbroken dimmable pause
			if (pause_m && pause_opts.dim_en) begin
				if (run_m < DIM_CYCLES) begin
					run_m <= run_m + 1;
				end
				if (run_m + 1 >= DIM_CYCLES) begin
					dim_m <= 1'b1;
				end
			end else begin
				run_m <= 0;
				dim_m <= 1'b0;
			end
			exp_controls <= ~{joy.coin, joy.start2p, joy.start1p, joy.fast_fire, joy.fire,
				joy.up, joy.down, joy.left, joy.right};
			// Cabinet bit is the MSB of byte 1
			exp_dip1   <= bank_m[1] & 8'h7f;
			exp_dip2   <= bank_m[2];
			exp_rom_wr <= rom_m;
			exp_rgb    <= dim_m ? {1'b0, rgb_in.r[2:1], 1'b0, rgb_in.g[2:1], 1'b0, rgb_in.b[1]}
				: rgb_in;
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	// LCG, upper half folded into the lower bits
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 16);
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic idle_inputs();
		beat         = '0;
		joy          = '0;
		osd_status   = 1'b0;
		hs_pause_req = 1'b0;
		pause_opts   = '0;
		rgb_in       = '0;
	endtask

	// Mixed index, mostly small addresses
	task automatic drive_random_beat();
		logic [31:0] r;
		logic [31:0] a;
		r = next_rand();
		a = next_rand();
		beat.wr    = r[0] | r[1];
		beat.index = (r[3:2] < 2'd2) ? DIP_INDEX : (r[3:2] == 2'd2) ? 8'd0 : r[15:8];
		beat.addr  = (r[5:4] != 2'd0) ? {22'd0, a[2:0]} : a[24:0];
		beat.dout  = r[31:24];
		rgb_in     = r[23:16];
	endtask

	// Let the 2-cycle paths settle inside the test
	task automatic flush();
		beat = '0;
		repeat (4) next_cycle();
	endtask

	// Watchdog sized from the test lengths
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [31:0]           r;
		frontend_pkg::rgb332_t pix;
		seed     = 32'h5dfd;
		rst_n    = 1'b0;
		check_en = 1'b0;
		dim_seen = 1'b0;
		idle_inputs();
		repeat (8) begin
			@(negedge clk_sys);
			checker_inst.expect_idle();
		end
		@(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		@(negedge clk_sys);
		checker_inst.expect_idle();
		checker_inst.report_test("reset state");
		// Stimulus starts just after the next rising edge
		next_cycle();
		check_en = 1'b1;

		for (int n = 0; n < N_DIP; n++) begin
			drive_random_beat();
			next_cycle();
		end
		flush();
		checker_inst.report_test("DIP capture");

		// ROM beats between idle gaps
		for (int n = 0; n < N_ROM; n++) begin
			r = next_rand();
			beat.wr    = r[0];
			beat.index = r[1] ? 8'd0 : r[15:8];
			beat.addr  = {r[31:16], r[8:0]};
			beat.dout  = r[23:16];
			next_cycle();
		end
		flush();
		checker_inst.report_test("ROM write");

		for (int n = 0; n < N_CTRL; n++) begin
			r = next_rand();
			joy    = r[15:0];
			rgb_in = r[23:16];
			next_cycle();
		end
		flush();
		checker_inst.report_test("control mapping");

		// Sources change now and then, so levels hold for a while
		idle_inputs();
		for (int n = 0; n < N_PAUSE; n++) begin
			r = next_rand();
			if (r[1:0] == 2'd0) joy.pause = ~joy.pause;
			if (r[4:2] == 3'd0) osd_status = ~osd_status;
			if (r[7:5] == 3'd0) pause_opts.pause_on_osd = ~pause_opts.pause_on_osd;
			if (r[10:8] == 3'd0) hs_pause_req = ~hs_pause_req;
			pause_opts.dim_en = r[11];
			rgb_in = r[23:16];
			next_cycle();
		end
		flush();
		checker_inst.report_test("pause sources");

		// Start from an unpaused toggle
		idle_inputs();
		next_cycle();
		if (toggle_m) begin
			joy.pause = 1'b1;
			next_cycle();
			joy.pause = 1'b0;
		end
		next_cycle();
		hs_pause_req = 1'b1;
		pix          = '0;
		for (int n = 0; n < 130; n++) begin
			pause_opts.dim_en = !(n >= 40 && n < 60);
			if (n == 100) hs_pause_req = 1'b0;
			r      = next_rand();
			pix    = r[7:0];
			rgb_in = pix;
			next_cycle();
			// Pixel is on rgb_out now, any change means the DUT dimmed it
			if (rgb_out !== pix) dim_seen = 1'b1;
		end
		if (!dim_seen) checker_inst.fail_note("picture never dimmed during a long dimmable pause");
		// Last pixel comes out at full brightness
		checker_inst.compare("rgb_out", pix, rgb_out);
		flush();
		checker_inst.report_test("dimming");

		checker_inst.report_totals();
		if (total_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
